// File: hw/ahb_sram.sv
/* AHB-Lite RAM slave of mem_words 32-bit words; HRDATA is zero except in
   an in-range read data phase, and errors answer addresses past the end */
`timescale 1ns/1ps

module ahb_sram
  import dbg_ahb_pkg::*;
#(
  parameter int mem_words   = 256,
  parameter int wait_states = 2
) (
  input  logic              HCLK,
  input  logic              ahb_rstn,
  input  logic              HSEL,
  input  logic [addr_w-1:0] HADDR,
  input  logic [data_w-1:0] HWDATA,
  input  logic              HWRITE,
  input  logic [2:0]        HSIZE,
  input  logic [1:0]        HTRANS,
  output logic [data_w-1:0] HRDATA,
  output logic              HREADY,
  output logic              HRESP
);

  localparam int idx_w = $clog2(mem_words);
  localparam int cnt_w = (wait_states > 0) ? $clog2(wait_states + 1) : 1;
  localparam logic [addr_w-1:0] mem_bytes = addr_w'(mem_words * 4);

  logic [data_w-1:0] mem [mem_words];

  logic              addr_ph;
  logic              dp_act;
  logic              dp_err;
  logic              err_late;
  logic [cnt_w-1:0]  wcnt;
  logic              dp_write;
  logic [2:0]        dp_size;
  logic [idx_w-1:0]  dp_idx;
  logic [1:0]        dp_lo;
  logic [3:0]        be;
  logic              wr_done;

  //////////////////////////////
  // Address phase
  //////////////////////////////

  // Only nonseq is expected, idle is ignored
  assign addr_ph = HSEL & (HTRANS == htrans_nonseq) & HREADY;

  always_ff @(posedge HCLK) begin
    if (addr_ph) begin
      dp_write <= HWRITE;
      dp_size  <= HSIZE;
      dp_idx   <= HADDR[idx_w+1:2];
      dp_lo    <= HADDR[1:0];
    end
  end

  //////////////////////////////
  // Data phase control
  //////////////////////////////

  // Wait counter runs down to zero, then HREADY goes high
  // Error path is a fixed two cycles with HRESP high
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dp_act   <= 1'b0;
      dp_err   <= 1'b0;
      err_late <= 1'b0;
      wcnt     <= '0;
    end else begin
      if (dp_act) begin
        if (dp_err) begin
          err_late <= 1'b1;
          if (err_late) begin
            dp_act <= 1'b0;
          end
        end else if (wcnt != '0) begin
          wcnt <= wcnt - 1'b1;
        end else begin
          dp_act <= 1'b0;
        end
      end
      // New address phase overlaps the last data cycle
      if (addr_ph) begin
        dp_act   <= 1'b1;
        dp_err   <= (HADDR >= mem_bytes);
        err_late <= 1'b0;
        wcnt     <= cnt_w'(wait_states);
      end
    end
  end

  always_comb begin
    HREADY = 1'b1;
    HRESP  = 1'b0;
    if (dp_act) begin
      if (dp_err) begin
        HREADY = err_late;
        HRESP  = 1'b1;
      end else begin
        HREADY = (wcnt == '0);
      end
    end
  end

  //////////////////////////////
  // Memory array
  //////////////////////////////

  // Byte enables, little-endian lane order
  always_comb begin
    case (dp_size)
      hsize_byte:  be = 4'b0001 << dp_lo;
      hsize_hword: be = 4'b0011 << {dp_lo[1], 1'b0};
      default:     be = 4'b1111;
    endcase
  end

  // Write lands on the last data-phase cycle, when HWDATA is valid
  assign wr_done = dp_act & ~dp_err & dp_write & (wcnt == '0);

  always_ff @(posedge HCLK) begin
    if (wr_done) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          mem[dp_idx][8*b +: 8] <= HWDATA[8*b +: 8];
        end
      end
    end
  end

  assign HRDATA = (dp_act && !dp_write && !dp_err) ? mem[dp_idx] : '0;

endmodule

// File: hw/dbg_ahb_biu.sv
/* Single-transfer AHB-Lite master fed from the debug clock domain; the
   transport must wait for biu_rdy, strobes while busy are dropped */
`timescale 1ns/1ps

module dbg_ahb_biu
  import dbg_ahb_pkg::*;
(
  input  logic              biu_clk,
  input  logic              HCLK,
  input  logic              ahb_rstn,
  input  logic [data_w-1:0] biu_di,
  input  logic [addr_w-1:0] biu_addr,
  input  logic              biu_strb,
  input  logic              biu_rw,
  input  logic [3:0]        biu_word_size,
  output logic [data_w-1:0] biu_do,
  output logic              biu_rdy,
  output logic              biu_err,
  output logic              HSEL,
  output logic [addr_w-1:0] HADDR,
  output logic [data_w-1:0] HWDATA,
  output logic              HWRITE,
  output logic [2:0]        HSIZE,
  output logic [2:0]        HBURST,
  output logic [3:0]        HPROT,
  output logic [1:0]        HTRANS,
  output logic              HMASTLOCK,
  input  logic [data_w-1:0] HRDATA,
  input  logic              HREADY,
  input  logic              HRESP
);

  // Transfer FSM states
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_addr = 2'd1;
  localparam logic [1:0] st_data = 2'd2;

  // Per-domain reset synchronizers
  logic [1:0]        biu_rst_q;
  logic              biu_rstn;
  logic [1:0]        ahb_rst_q;
  logic              hclk_rstn;
  // Debug side request
  logic              accept;
  logic [data_w-1:0] wdata_q;
  logic              start_tgl;
  logic              rdy_pulse;
  // AHB side
  logic              start_pulse;
  logic              start_hold;
  logic              rdy_tgl;
  logic [1:0]        state;
  logic              xfer_ack;
  logic [data_w-1:0] rd_steered;

  //////////////////////////////
  // Reset synchronizers
  //////////////////////////////

  // Assert at once, release two clocks later in each domain
  always_ff @(posedge biu_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      biu_rst_q <= 2'b00;
    end else begin
      biu_rst_q <= {biu_rst_q[0], 1'b1};
    end
  end
  assign biu_rstn = biu_rst_q[1];

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      ahb_rst_q <= 2'b00;
    end else begin
      ahb_rst_q <= {ahb_rst_q[0], 1'b1};
    end
  end
  assign hclk_rstn = ahb_rst_q[1];

  //////////////////////////////
  // Debug clock domain
  //////////////////////////////

  assign accept = biu_strb & biu_rdy;

  // Request latches; held stable for the whole AHB transfer
  always_ff @(posedge biu_clk or negedge biu_rstn) begin
    if (!biu_rstn) begin
      HADDR  <= '0;
      HWRITE <= 1'b0;
      HSIZE  <= hsize_word;
    end else if (accept) begin
      HADDR  <= biu_addr;
      HWRITE <= ~biu_rw;
      case (biu_word_size)
        size_byte:  HSIZE <= hsize_byte;
        size_hword: HSIZE <= hsize_hword;
        size_word:  HSIZE <= hsize_word;
        default:    HSIZE <= hsize_word;
      endcase
    end
  end

  // Raw write word, lanes are steered afterwards by the latched size
  always_ff @(posedge biu_clk) begin
    if (accept) begin
      wdata_q <= biu_di;
    end
  end

  // Start toggle out, busy flag back in
  always_ff @(posedge biu_clk or negedge biu_rstn) begin
    if (!biu_rstn) begin
      start_tgl <= 1'b0;
      biu_rdy   <= 1'b1;
    end else if (accept) begin
      start_tgl <= ~start_tgl;
      biu_rdy   <= 1'b0;
    end else if (rdy_pulse) begin
      biu_rdy   <= 1'b1;
    end
  end

  dbg_toggle_sync u_rdy_sync (
    .dst_clk   (biu_clk),
    .rst_n     (biu_rstn),
    .toggle_in (rdy_tgl),
    .pulse     (rdy_pulse)
  );

  dbg_lane_steer u_steer (
    .size    (HSIZE),
    .addr_lo (HADDR[1:0]),
    .wr_in   (wdata_q),
    .wr_out  (HWDATA),
    .rd_in   (HRDATA),
    .rd_out  (rd_steered)
  );

  //////////////////////////////
  // AHB clock domain
  //////////////////////////////

  dbg_toggle_sync u_start_sync (
    .dst_clk   (HCLK),
    .rst_n     (hclk_rstn),
    .toggle_in (start_tgl),
    .pulse     (start_pulse)
  );

  // Data phase done on first HREADY high
  assign xfer_ack = (state == st_data) & HREADY;

  // idle -> addr (nonseq on bus) -> data (idle on bus, wait for HREADY)
  always_ff @(posedge HCLK or negedge hclk_rstn) begin
    if (!hclk_rstn) begin
      state      <= st_idle;
      HTRANS     <= htrans_idle;
      start_hold <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          start_hold <= 1'b0;
          if (start_pulse || start_hold) begin
            state  <= st_addr;
            HTRANS <= htrans_nonseq;
          end
        end
        st_addr: begin
          state  <= st_data;
          HTRANS <= htrans_idle;
        end
        st_data: begin
          if (HREADY) begin
            state <= st_idle;
          end
        end
        default: begin
          state  <= st_idle;
          HTRANS <= htrans_idle;
        end
      endcase
      // Remember a start that lands mid-transfer
      if (state != st_idle && start_pulse) begin
        start_hold <= 1'b1;
      end
    end
  end

  // Response status and completion toggle
  always_ff @(posedge HCLK or negedge hclk_rstn) begin
    if (!hclk_rstn) begin
      biu_err <= 1'b0;
      rdy_tgl <= 1'b0;
    end else if (xfer_ack) begin
      biu_err <= HRESP;
      rdy_tgl <= ~rdy_tgl;
    end
  end

  // Read result, settled well before biu_rdy rises on the debug side
  always_ff @(posedge HCLK) begin
    if (xfer_ack) begin
      biu_do <= rd_steered;
    end
  end

  // Fixed master attributes
  assign HSEL      = 1'b1;
  assign HMASTLOCK = 1'b0;
  assign HBURST    = hburst_single;
  assign HPROT     = hprot_dbg;

endmodule

// File: hw/dbg_ahb_pkg.sv
/* Bus encodings for a 32-bit little-endian AHB-Lite debug master
   Only idle and nonseq transfers exist, since bursts are not issued */
package dbg_ahb_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int addr_w = 32;
  localparam int data_w = 32;

  //////////////////////////////
  // AHB transfer types
  //////////////////////////////

  // Busy and seq are never driven by this master
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  //////////////////////////////
  // AHB size and burst codes
  //////////////////////////////

  localparam logic [2:0] hsize_byte  = 3'b000;
  localparam logic [2:0] hsize_hword = 3'b001;
  localparam logic [2:0] hsize_word  = 3'b010;

  // Every transfer is a single beat
  localparam logic [2:0] hburst_single = 3'b000;

  //////////////////////////////
  // AHB protection
  //////////////////////////////

  // Bit 0 data access, bit 1 privileged
  // Bits 2 and 3 left clear, so non-bufferable and non-cacheable
  localparam logic [3:0] hprot_data = 4'b0001;
  localparam logic [3:0] hprot_priv = 4'b0010;
  localparam logic [3:0] hprot_dbg  = hprot_data | hprot_priv;

  //////////////////////////////
  // Debug-side access sizes
  //////////////////////////////

  // Byte counts as sent by the debug transport
  // Anything else is treated as a full word
  localparam logic [3:0] size_byte  = 4'd1;
  localparam logic [3:0] size_hword = 4'd2;
  localparam logic [3:0] size_word  = 4'd4;

endpackage

// File: hw/dbg_ahb_top.sv
/* Debug bridge plus local RAM; addresses at or past mem_words*4 return
   a bus error and leave the memory untouched */
`timescale 1ns/1ps

module dbg_ahb_top
  import dbg_ahb_pkg::*;
#(
  parameter int mem_words   = 256,
  parameter int wait_states = 2
) (
  input  logic              biu_clk,
  input  logic              HCLK,
  input  logic              ahb_rstn,
  input  logic [data_w-1:0] biu_di,
  input  logic [addr_w-1:0] biu_addr,
  input  logic              biu_strb,
  input  logic              biu_rw,
  input  logic [3:0]        biu_word_size,
  output logic [data_w-1:0] biu_do,
  output logic              biu_rdy,
  output logic              biu_err
);

  // Master to slave
  logic              hsel;
  logic [addr_w-1:0] haddr;
  logic [data_w-1:0] hwdata;
  logic              hwrite;
  logic [2:0]        hsize;
  logic [1:0]        htrans;
  // Slave to master
  logic [data_w-1:0] hrdata;
  logic              hready;
  logic              hresp;

  // HBURST, HPROT and HMASTLOCK are constant and the RAM has no use for them
  dbg_ahb_biu u_biu (
    .biu_clk       (biu_clk),
    .HCLK          (HCLK),
    .ahb_rstn      (ahb_rstn),
    .biu_di        (biu_di),
    .biu_addr      (biu_addr),
    .biu_strb      (biu_strb),
    .biu_rw        (biu_rw),
    .biu_word_size (biu_word_size),
    .biu_do        (biu_do),
    .biu_rdy       (biu_rdy),
    .biu_err       (biu_err),
    .HSEL          (hsel),
    .HADDR         (haddr),
    .HWDATA        (hwdata),
    .HWRITE        (hwrite),
    .HSIZE         (hsize),
    .HBURST        (),
    .HPROT         (),
    .HTRANS        (htrans),
    .HMASTLOCK     (),
    .HRDATA        (hrdata),
    .HREADY        (hready),
    .HRESP         (hresp)
  );

  // Single slave, so the master's HSEL drives it directly
  ahb_sram #(
    .mem_words   (mem_words),
    .wait_states (wait_states)
  ) u_sram (
    .HCLK     (HCLK),
    .ahb_rstn (ahb_rstn),
    .HSEL     (hsel),
    .HADDR    (haddr),
    .HWDATA   (hwdata),
    .HWRITE   (hwrite),
    .HSIZE    (hsize),
    .HTRANS   (htrans),
    .HRDATA   (hrdata),
    .HREADY   (hready),
    .HRESP    (hresp)
  );

endmodule

// File: hw/dbg_lane_steer.sv
/* Lane steering for a 32-bit little-endian bus; narrow write data comes
   from the top of wr_in, narrow read data is zero-extended */
`timescale 1ns/1ps

module dbg_lane_steer
  import dbg_ahb_pkg::*;
(
  input  logic [2:0]        size,
  input  logic [1:0]        addr_lo,
  input  logic [data_w-1:0] wr_in,
  output logic [data_w-1:0] wr_out,
  input  logic [data_w-1:0] rd_in,
  output logic [data_w-1:0] rd_out
);

  //////////////////////////////
  // Write lanes
  //////////////////////////////

  // Debug transport left-aligns narrow data
  // Replicating it puts the right bytes on whichever lane the slave picks
  always_comb begin : wr_lanes
    case (size)
      hsize_byte: begin
        wr_out = {4{wr_in[data_w-1 -: 8]}};
      end
      hsize_hword: begin
        wr_out = {2{wr_in[data_w-1 -: 16]}};
      end
      default: begin
        wr_out = wr_in;
      end
    endcase
  end

  //////////////////////////////
  // Read lanes
  //////////////////////////////

  // Pick the addressed lane, little-endian order
  // Upper bits stay zero for narrow reads
  always_comb begin : rd_lanes
    rd_out = '0;
    case (size)
      hsize_byte: begin
        case (addr_lo)
          2'b00:   rd_out[7:0] = rd_in[7:0];
          2'b01:   rd_out[7:0] = rd_in[15:8];
          2'b10:   rd_out[7:0] = rd_in[23:16];
          default: rd_out[7:0] = rd_in[31:24];
        endcase
      end
      hsize_hword: begin
        // Bit 0 of the address is ignored for halfwords
        if (addr_lo[1]) begin
          rd_out[15:0] = rd_in[31:16];
        end else begin
          rd_out[15:0] = rd_in[15:0];
        end
      end
      default: begin
        rd_out = rd_in;
      end
    endcase
  end

endmodule

// File: hw/dbg_toggle_sync.sv
/* Toggle to pulse crossing; toggle_in must hold each level for at least
   two dst_clk cycles or consecutive flips merge into one pulse */
`timescale 1ns/1ps

module dbg_toggle_sync (
  input  logic dst_clk,
  input  logic rst_n,
  input  logic toggle_in,
  output logic pulse
);

  // Two metastability flops, third one keeps the previous level
  logic sync_q1;
  logic sync_q2;
  logic sync_q3;

  always_ff @(posedge dst_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      sync_q3 <= 1'b0;
    end else begin
      sync_q1 <= toggle_in;
      sync_q2 <= sync_q1;
      sync_q3 <= sync_q2;
    end
  end

  // Any change of the settled level is one event
  assign pulse = sync_q2 ^ sync_q3;

endmodule

// File: project.f
hw/dbg_ahb_pkg.sv
hw/dbg_toggle_sync.sv
hw/dbg_lane_steer.sv
hw/dbg_ahb_biu.sv
hw/ahb_sram.sv
hw/dbg_ahb_top.sv
verification/dbg_ahb_chk.sv
verification/dbg_ahb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the debug AHB bridge testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module dbg_ahb_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vdbg_ahb_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0

// File: verification/dbg_ahb_chk.sv
/* Bus protocol checks bound into dbg_ahb_biu; they are gated by the
   bridge's own synchronized resets */
`timescale 1ns/1ps

module dbg_ahb_chk
  import dbg_ahb_pkg::*;
(
  input logic       HCLK,
  input logic       biu_clk,
  input logic       hclk_rstn,
  input logic       biu_rstn,
  input logic [1:0] HTRANS,
  input logic [2:0] HSIZE,
  input logic       biu_strb,
  input logic       biu_rdy
);

  //////////////////////////////
  // AHB side
  //////////////////////////////

  // Master only issues single transfers
  a_htrans_legal: assert property (@(posedge HCLK) disable iff (!hclk_rstn)
      (HTRANS == htrans_idle) || (HTRANS == htrans_nonseq))
    else $error("HTRANS drove busy or seq");

  // Address phase lasts one cycle
  a_nonseq_then_idle: assert property (@(posedge HCLK) disable iff (!hclk_rstn)
      (HTRANS == htrans_nonseq) |=> (HTRANS == htrans_idle))
    else $error("nonseq cycle not followed by idle");

  a_hsize_max: assert property (@(posedge HCLK) disable iff (!hclk_rstn)
      HSIZE <= hsize_word)
    else $error("HSIZE wider than a word");

  //////////////////////////////
  // Debug side
  //////////////////////////////

  // Busy must show on the edge after acceptance
  a_rdy_drops: assert property (@(posedge biu_clk) disable iff (!biu_rstn)
      (biu_strb && biu_rdy) |=> !biu_rdy)
    else $error("biu_rdy still high after an accepted strobe");

endmodule

// File: verification/dbg_ahb_tb.sv
/* Directed and random debug accesses checked against a byte model of the RAM;
   bytes never written are masked out of read compares */
`timescale 1ns/1ps

module dbg_ahb_tb
  import dbg_ahb_pkg::*;
();

  localparam int mem_words         = 256;
  localparam int wait_states       = 2;
  localparam int mem_bytes         = mem_words * 4;
  localparam int n_random          = 400;
  // Directed accesses, rounded up
  localparam int n_directed        = 60;
  localparam int cycles_per_access = 40;
  localparam int timeout_cycles    = (n_random + n_directed) * cycles_per_access;
  // Target of the requests held on the bus while busy
  localparam logic [31:0] guard_addr = 32'h3fc;

  logic        HCLK;
  logic        biu_clk;
  logic        ahb_rstn;
  logic [31:0] biu_di;
  logic [31:0] biu_addr;
  logic        biu_strb;
  logic        biu_rw;
  logic [3:0]  biu_word_size;
  logic [31:0] biu_do;
  logic        biu_rdy;
  logic        biu_err;

  // Reference memory, one flag per byte once written
  logic [7:0]  mem_model [mem_bytes];
  logic        byte_known [mem_bytes];
  int          seed;
  int          cycle_count = 0;
  logic [31:0] r;
  logic [31:0] r2;
  logic [31:0] addr;
  logic [31:0] addrs [8];
  logic [3:0]  wsize;

  dbg_ahb_top #(
    .mem_words   (mem_words),
    .wait_states (wait_states)
  ) u_dut (
    .biu_clk       (biu_clk),
    .HCLK          (HCLK),
    .ahb_rstn      (ahb_rstn),
    .biu_di        (biu_di),
    .biu_addr      (biu_addr),
    .biu_strb      (biu_strb),
    .biu_rw        (biu_rw),
    .biu_word_size (biu_word_size),
    .biu_do        (biu_do),
    .biu_rdy       (biu_rdy),
    .biu_err       (biu_err)
  );

  bind dbg_ahb_biu dbg_ahb_chk u_chk (
    .HCLK      (HCLK),
    .biu_clk   (biu_clk),
    .hclk_rstn (hclk_rstn),
    .biu_rstn  (biu_rstn),
    .HTRANS    (HTRANS),
    .HSIZE     (HSIZE),
    .biu_strb  (biu_strb),
    .biu_rdy   (biu_rdy)
  );

  always #4 HCLK = ~HCLK;
  always #13 biu_clk = ~biu_clk;

  // Watchdog
  always @(posedge HCLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: no end of test after %0d HCLK cycles", cycle_count);
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
    end
  end

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  // Debug size code to byte count, unknown codes are words
  function automatic int size_bytes(input logic [3:0] code);
    case (code)
      size_byte:  return 1;
      size_hword: return 2;
      default:    return 4;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Narrow value sits at the top of di, stored little-endian from the aligned base
  task automatic model_write(input logic [31:0] a, input logic [3:0] code,
                             input logic [31:0] di);
    int          n;
    int          base;
    logic [31:0] nv;
    n    = size_bytes(code);
    base = int'(a) & ~(n - 1);
    nv   = di >> (32 - 8 * n);
    for (int k = 0; k < n; k++) begin
      mem_model[base + k]  = nv[8*k +: 8];
      byte_known[base + k] = 1'b1;
    end
  endtask

  task automatic model_read(input logic [31:0] a, input logic [3:0] code,
                            output logic [31:0] val, output logic [31:0] known);
    int n;
    int base;
    n     = size_bytes(code);
    base  = int'(a) & ~(n - 1);
    val   = '0;
    // Bits above the access size are always compared, they must be zero
    known = '1;
    for (int k = 0; k < n; k++) begin
      val[8*k +: 8]   = mem_model[base + k];
      known[8*k +: 8] = {8{byte_known[base + k]}};
    end
  endtask

  // Entered 1 ns after a biu_clk edge with biu_rdy high, left the same way
  task automatic do_access(input logic rd, input logic [3:0] code,
                           input logic [31:0] a, input logic [31:0] di,
                           input logic hold);
    logic        exp_err;
    logic [31:0] exp_do;
    logic [31:0] known;
    biu_strb      = 1'b1;
    biu_rw        = rd;
    biu_addr      = a;
    biu_di        = di;
    biu_word_size = code;
    @(posedge biu_clk);
    #1;
    check_value("biu_rdy", {31'd0, biu_rdy}, 32'd0);
    if (hold) begin
      // A different write stays on the bus, it must not be taken
      biu_rw        = 1'b0;
      biu_addr      = guard_addr;
      biu_di        = ~di;
      biu_word_size = size_word;
    end else begin
      biu_strb = 1'b0;
    end
    while (!biu_rdy) begin
      @(posedge biu_clk);
      #1;
    end
    biu_strb = 1'b0;
    exp_err  = (a >= 32'(mem_bytes));
    check_value("biu_err", {31'd0, biu_err}, {31'd0, exp_err});
    if (rd && !exp_err) begin
      model_read(a, code, exp_do, known);
      check_value("biu_do", biu_do & known, exp_do & known);
    end
    if (!rd && !exp_err) begin
      model_write(a, code, di);
    end
  endtask

  initial begin
    seed          = 32'h50a2d68b;
    HCLK          = 1'b0;
    biu_clk       = 1'b0;
    ahb_rstn      = 1'b0;
    biu_strb      = 1'b0;
    biu_rw        = 1'b0;
    biu_addr      = '0;
    biu_di        = '0;
    biu_word_size = size_word;
    for (int i = 0; i < mem_bytes; i++) begin
      mem_model[i]  = 8'h00;
      byte_known[i] = 1'b0;
    end
    repeat (3) @(posedge HCLK);
    #1 ahb_rstn = 1'b1;
    // Let both reset synchronizers release
    repeat (3) @(posedge biu_clk);
    #1;
    check_value("biu_rdy", {31'd0, biu_rdy}, 32'd1);
    check_value("biu_err", {31'd0, biu_err}, 32'd0);

    ////////////////////////////////
    // Word writes then reads
    for (int i = 0; i < 8; i++) begin
      r        = next_rand();
      addrs[i] = {23'd0, r[8:2], 2'b00};
      do_access(1'b0, size_word, addrs[i], next_rand(), 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      do_access(1'b1, size_word, addrs[i], 32'd0, 1'b0);
    end

    ////////////////////////////////
    // Narrow writes and reads at every offset
    for (int k = 0; k < 4; k++) begin
      do_access(1'b0, size_byte, 32'h40 + k, next_rand(), 1'b0);
    end
    for (int k = 0; k < 2; k++) begin
      do_access(1'b0, size_hword, 32'h48 + 2 * k, next_rand(), 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
      do_access(1'b1, size_byte, 32'h40 + k, 32'd0, 1'b0);
      do_access(1'b1, size_byte, 32'h48 + k, 32'd0, 1'b0);
      do_access(1'b1, size_hword, 32'h40 + 2 * (k % 2) + 8 * (k / 2), 32'd0, 1'b0);
    end
    do_access(1'b1, size_word, 32'h40, 32'd0, 1'b0);
    do_access(1'b1, size_word, 32'h48, 32'd0, 1'b0);

    ////////////////////////////////
    // Errors past the end; 0x410 would alias word 0x10
    do_access(1'b0, size_word, 32'h10, 32'hc0ffee11, 1'b0);
    do_access(1'b0, size_word, 32'h410, 32'h5a5a5a5a, 1'b0);
    do_access(1'b1, size_word, 32'h510, 32'd0, 1'b0);
    do_access(1'b1, size_byte, 32'hfffffff1, 32'd0, 1'b0);
    do_access(1'b1, size_word, 32'h10, 32'd0, 1'b0);

    ////////////////////////////////
    // Strobe held high while busy
    do_access(1'b0, size_word, guard_addr, 32'h600dcafe, 1'b0);
    for (int k = 0; k < 4; k++) begin
      do_access(1'b0, size_word, 32'h100 + 4 * k, next_rand(), 1'b1);
    end
    do_access(1'b1, size_word, guard_addr, 32'd0, 1'b0);
    for (int k = 0; k < 4; k++) begin
      do_access(1'b1, size_word, 32'h100 + 4 * k, 32'd0, 1'b0);
    end

    ////////////////////////////////
    // Random mix
    for (int i = 0; i < n_random; i++) begin
      r  = next_rand();
      r2 = next_rand();
      case (r[3:2])
        2'd0:    wsize = size_byte;
        2'd1:    wsize = size_hword;
        2'd2:    wsize = size_word;
        default: wsize = {r[5:4], 2'b11};
      endcase
      // About one in ten goes past the end of the RAM
      if ((r2 % 32'd10) == 32'd0) begin
        addr = r2[12] ? (32'h400 + {20'd0, r2[23:12]}) : {1'b1, r2[30:0]};
      end else begin
        addr = r2[11] ? {22'd0, r2[25:16]} : {24'd0, r2[23:16]};
      end
      do_access(r[0], wsize, addr, next_rand(), r[9:8] == 2'b00);
      repeat (int'(r[14:13])) @(posedge biu_clk);
      #1;
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule
